//--- rtl/cpl_consts.svh
`ifndef CPL_CONSTS_SVH
`define CPL_CONSTS_SVH

// --------------------------------------------------
// Stream and header geometry
// --------------------------------------------------
`define CPL_BEAT_W      128     // One stream beat, 4 DW
`define CPL_HDR_W       96      // 3-DW completion header
`define CPL_PAYLOAD_W   256     // Payload held per command, 8 DW

// --------------------------------------------------
// Command field widths
// --------------------------------------------------
`define CPL_MAX_BYTES   32      // Payload cap in bytes
`define CPL_BC_W        12      // Byte count field
`define CPL_TAG_W       8       // Request tag
`define CPL_ID_W        16      // Bus/dev/func ID
`define CPL_BEAT_CNT_W  2       // Up to two data beats

// --------------------------------------------------
// Format/type bytes
// --------------------------------------------------
`define CPL_FMT_CPL     8'h0A   // Completion, no data
`define CPL_FMT_CPLD    8'h4A   // Completion with data

`endif

//--- rtl/tl_stream_pkg.sv
`include "cpl_consts.svh"

package tl_stream_pkg;

  // --------------------------------------------------
  // Transaction-layer stream beat
  // --------------------------------------------------
  typedef struct packed {
    logic [`CPL_BEAT_W-1:0] data;  // Four DWs, DW0 in low bits
    logic [3:0]             be;    // Byte enables of the payload DW
    logic                   sop;   // First beat of a TLP
    logic                   eop;   // Last beat of a TLP
  } tl_beat_t;

endpackage

//--- rtl/cpl_pkg.sv
`include "cpl_consts.svh"

package cpl_pkg;

  typedef enum logic [2:0] {
    CPL_SC  = 3'd0,  // Successful completion
    CPL_UR  = 3'd1,  // Unsupported request
    CPL_CRS = 3'd2   // Config retry
  } cpl_status_e;

  typedef enum logic [1:0] {
    ST_IDLE,       // Waiting for a command
    ST_GEN_HDR,    // Header register loads
    ST_SEND_HDR,   // Header beat offered
    ST_SEND_DATA   // Data beats offered
  } cpl_state_e;

  // --------------------------------------------------
  // Completion command from the request side
  // --------------------------------------------------
  typedef struct packed {
    cpl_status_e               status;
    logic                      has_data;
    logic [`CPL_ID_W-1:0]      requester_id;
    logic [`CPL_TAG_W-1:0]     tag;
    logic [6:0]                lower_addr;
    logic [`CPL_BC_W-1:0]      byte_count;
    logic [3:0]                first_be;
    logic [3:0]                last_be;
    logic [`CPL_PAYLOAD_W-1:0] data;
  } cpl_cmd_t;

  // --------------------------------------------------
  // 3-DW completion header, MSB first
  // --------------------------------------------------
  typedef struct packed {
    logic        rsvd_95;      // Bit 95
    logic [6:0]  lower_addr;   // Bits 94:88
    logic [7:0]  tag;          // Byte 10
    logic [7:0]  req_id_lo;    // Byte 9
    logic [7:0]  req_id_hi;    // Byte 8
    logic [7:0]  byte_cnt_lo;  // Byte 7
    cpl_status_e status;       // Bits 55:53
    logic        bcm;          // Bit 52
    logic [3:0]  byte_cnt_hi;  // Bits 51:48
    logic [7:0]  cpl_id_lo;    // Byte 5
    logic [7:0]  cpl_id_hi;    // Byte 4
    logic [7:0]  len_lo;       // Byte 3
    logic [7:0]  len_hi;       // Byte 2, two MSBs only
    logic [7:0]  rsvd_b1;      // Byte 1
    logic [7:0]  fmt_type;     // Byte 0
  } cpl_hdr_t;

endpackage

//--- rtl/cpl_ctrl.sv
`timescale 1ns/1ps
`include "cpl_consts.svh"

module cpl_ctrl
  import cpl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cpl_cmd_t   cpl_cmd_i,
  input  logic       cmd_valid_i,
  input  logic       cred_hdr_ok_i,
  input  logic       cred_data_ok_i,
  input  logic       pkt_ready_i,
  output logic       cmd_ready_o,
  output cpl_cmd_t   cmd_q,
  output logic       hdr_load,
  output logic [1:0] beat_sel,
  output logic       last_beat,
  output logic       pkt_valid_o
);

  cpl_state_e                 state_q, state_d;
  cpl_cmd_t                   cmd_in;
  logic                       cmd_acc;        // Command handshake
  logic                       pkt_xfer;       // Beat handshake
  logic [`CPL_BC_W-1:0]       bc_cap;         // Byte count clamped to the cap
  logic [`CPL_BC_W-1:0]       bc_round;       // Bytes past DW0 plus 15
  logic [`CPL_BEAT_CNT_W-1:0] nbeats_in;      // Data beats of the new command
  logic [`CPL_BEAT_CNT_W-1:0] nbeats_q;
  logic [`CPL_BEAT_CNT_W-1:0] beat_cnt_q;     // Data beats already sent

  assign cmd_ready_o = (state_q == ST_IDLE);
  assign cmd_acc     = cmd_valid_i && cmd_ready_o;
  assign pkt_xfer    = pkt_valid_o && pkt_ready_i;
  assign hdr_load    = (state_q == ST_GEN_HDR);

  // --------------------------------------------------
  // Command capture and beat count
  // --------------------------------------------------
  always_comb begin
    cmd_in          = cpl_cmd_i;
    cmd_in.has_data = cpl_cmd_i.has_data && (cpl_cmd_i.status == CPL_SC);  // UR/CRS never carry data
  end

  assign bc_cap   = (cmd_in.byte_count > `CPL_BC_W'(`CPL_MAX_BYTES)) ?
                    `CPL_BC_W'(`CPL_MAX_BYTES) : cmd_in.byte_count;
  assign bc_round = bc_cap + `CPL_BC_W'(11);  // (bc - 4 + 15)

  // ceil((bc - 4) / 16), header beat carries DW0
  assign nbeats_in = (cmd_in.has_data && (bc_cap > `CPL_BC_W'(4))) ?
                     bc_round[`CPL_BEAT_CNT_W+3:4] : '0;

  always_ff @(posedge clk) begin
    if (cmd_acc) begin
      cmd_q <= cmd_in;  // Held until the next acceptance
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nbeats_q <= '0;
    end else if (cmd_acc) begin
      nbeats_q <= nbeats_in;
    end
  end

  // --------------------------------------------------
  // Sequencing FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:      if (cmd_valid_i) state_d = ST_GEN_HDR;
      ST_GEN_HDR:   state_d = ST_SEND_HDR;          // Header register loads here
      ST_SEND_HDR: begin
        if (pkt_xfer) begin
          state_d = (nbeats_q == '0) ? ST_IDLE : ST_SEND_DATA;
        end
      end
      ST_SEND_DATA: if (pkt_xfer && last_beat) state_d = ST_IDLE;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
    end else if (state_q == ST_IDLE) begin
      beat_cnt_q <= '0;                               // Fresh count per completion
    end else if ((state_q == ST_SEND_DATA) && pkt_xfer) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // Beat select, last flag and valid
  // --------------------------------------------------
  always_comb begin
    beat_sel    = 2'd0;  // Header beat
    last_beat   = (nbeats_q == '0);
    pkt_valid_o = 1'b0;
    case (state_q)
      ST_SEND_HDR: begin
        // CplD header beat also spends data credit for DW0
        pkt_valid_o = cred_hdr_ok_i && (!cmd_q.has_data || cred_data_ok_i);
      end
      ST_SEND_DATA: begin
        beat_sel    = beat_cnt_q + 2'd1;  // Data beat 0 or 1
        last_beat   = (beat_cnt_q == nbeats_q - 2'd1);
        pkt_valid_o = cred_data_ok_i;
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/cpl_hdr_build.sv
`timescale 1ns/1ps
`include "cpl_consts.svh"

module cpl_hdr_build
  import cpl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hdr_load,
  input  cpl_cmd_t             cmd_q,
  input  logic [`CPL_ID_W-1:0] completer_id_i,
  output cpl_hdr_t             hdr_q
);

  logic [`CPL_BC_W-1:0] bc_plus3;  // Byte count rounded up to a DW
  logic [9:0]           len_dw;    // Length field in DW

  assign bc_plus3 = cmd_q.byte_count + `CPL_BC_W'(3);
  assign len_dw   = cmd_q.has_data ? bc_plus3[`CPL_BC_W-1:2] : 10'd0;  // Cpl has no length

  // --------------------------------------------------
  // Header register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hdr_q <= '0;
    end else if (hdr_load) begin
      hdr_q.fmt_type    <= cmd_q.has_data ? `CPL_FMT_CPLD : `CPL_FMT_CPL;
      hdr_q.rsvd_b1     <= 8'h00;                 // TC 0, no attributes
      hdr_q.len_hi      <= {6'b0, len_dw[9:8]};
      hdr_q.len_lo      <= len_dw[7:0];
      hdr_q.cpl_id_hi   <= completer_id_i[15:8];
      hdr_q.cpl_id_lo   <= completer_id_i[7:0];
      hdr_q.status      <= cmd_q.status;
      hdr_q.bcm         <= 1'b0;
      hdr_q.byte_cnt_hi <= cmd_q.byte_count[11:8];
      hdr_q.byte_cnt_lo <= cmd_q.byte_count[7:0];
      hdr_q.req_id_hi   <= cmd_q.requester_id[15:8];
      hdr_q.req_id_lo   <= cmd_q.requester_id[7:0];
      hdr_q.tag         <= cmd_q.tag;
      hdr_q.lower_addr  <= cmd_q.lower_addr;
      hdr_q.rsvd_95     <= 1'b0;
    end
  end

endmodule

//--- rtl/cpl_beat_pack.sv
`timescale 1ns/1ps
`include "cpl_consts.svh"

module cpl_beat_pack
  import cpl_pkg::*;
  import tl_stream_pkg::*;
(
  input  logic [1:0] beat_sel,
  input  logic       last_beat,
  input  cpl_hdr_t   hdr_q,
  input  cpl_cmd_t   cmd_q,
  output tl_beat_t   pkt_o
);

  logic [31:0] dw0;  // First payload DW, rides with the header

  assign dw0 = cmd_q.has_data ? cmd_q.data[31:0] : 32'h0;

  // --------------------------------------------------
  // Beat mux
  // --------------------------------------------------
  always_comb begin
    pkt_o = '0;
    case (beat_sel)
      2'd1: begin  // Data beat 0, DW1..DW4
        pkt_o.data = cmd_q.data[159:32];
        pkt_o.be   = last_beat ? cmd_q.last_be : 4'hF;
        pkt_o.sop  = 1'b0;
        pkt_o.eop  = last_beat;
      end
      2'd2: begin  // Data beat 1, DW5..DW7
        pkt_o.data = {32'h0, cmd_q.data[255:160]};  // Upper DW padded
        pkt_o.be   = cmd_q.last_be;
        pkt_o.sop  = 1'b0;
        pkt_o.eop  = 1'b1;                          // Always final
      end
      default: begin  // Header beat
        pkt_o.data[`CPL_HDR_W-1:0]           = hdr_q;
        pkt_o.data[`CPL_BEAT_W-1:`CPL_HDR_W] = dw0;
        // Single-beat CplD: DW0 is also the last DW
        pkt_o.be  = (cmd_q.has_data && last_beat) ? cmd_q.first_be : 4'hF;
        pkt_o.sop = 1'b1;
        pkt_o.eop = last_beat;
      end
    endcase
  end

endmodule

//--- rtl/cpl_gen_top.sv
`timescale 1ns/1ps
`include "cpl_consts.svh"

module cpl_gen_top
  import cpl_pkg::*;
  import tl_stream_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`CPL_ID_W-1:0] completer_id_i,
  input  cpl_cmd_t             cpl_cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  logic                 cred_hdr_ok_i,
  input  logic                 cred_data_ok_i,
  output tl_beat_t             pkt_o,
  output logic                 pkt_valid_o,
  input  logic                 pkt_ready_i
);

  cpl_cmd_t   cmd_q;      // Held command
  cpl_hdr_t   hdr_q;      // Built header
  logic       hdr_load;   // ST_GEN_HDR pulse
  logic [1:0] beat_sel;   // Header, data 0, data 1
  logic       last_beat;

  // --------------------------------------------------
  // Sequencing
  // --------------------------------------------------
  cpl_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpl_cmd_i      (cpl_cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cred_hdr_ok_i  (cred_hdr_ok_i),
    .cred_data_ok_i (cred_data_ok_i),
    .pkt_ready_i    (pkt_ready_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_q          (cmd_q),
    .hdr_load       (hdr_load),
    .beat_sel       (beat_sel),
    .last_beat      (last_beat),
    .pkt_valid_o    (pkt_valid_o)
  );

  cpl_hdr_build u_hdr_build (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_load       (hdr_load),
    .cmd_q          (cmd_q),
    .completer_id_i (completer_id_i),
    .hdr_q          (hdr_q)
  );

  // Output beat, combinational from the held state
  cpl_beat_pack u_beat_pack (
    .beat_sel  (beat_sel),
    .last_beat (last_beat),
    .hdr_q     (hdr_q),
    .cmd_q     (cmd_q),
    .pkt_o     (pkt_o)
  );

endmodule

//--- tests/tb_cpl_gen.sv
`timescale 1ns/1ps
`include "cpl_consts.svh"

module tb_cpl_gen
  import cpl_pkg::*;
  import tl_stream_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int N_CMDS      = 300;
  localparam int WATCHDOG_NS = N_CMDS * 40 * CLK_PERIOD;  // 40 cycles per command

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [`CPL_ID_W-1:0] completer_id_i;
  cpl_cmd_t             cpl_cmd_i;
  logic                 cmd_valid_i, cmd_ready_o;
  logic                 cred_hdr_ok_i, cred_data_ok_i;
  tl_beat_t             pkt_o;
  logic                 pkt_valid_o, pkt_ready_i;

  integer   seed = 36406;
  int       n_acc = 0;      // Accepted commands
  int       n_gen = 0;      // Generated commands
  int       phase = 0;      // Model state: 0 idle, 1 header build, 2 sending
  logic     cmd_taken = 1'b0;
  tl_beat_t beat_q[$];      // Expected beats in order
  logic [1:0] need_q[$];    // Credits per beat, {hdr, data}

  always #(CLK_PERIOD / 2) clk = ~clk;

  cpl_gen_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .completer_id_i (completer_id_i),
    .cpl_cmd_i      (cpl_cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cred_hdr_ok_i  (cred_hdr_ok_i),
    .cred_data_ok_i (cred_data_ok_i),
    .pkt_o          (pkt_o),
    .pkt_valid_o    (pkt_valid_o),
    .pkt_ready_i    (pkt_ready_i)
  );

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------
  task automatic report_error(string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, string exp_s, string act_s);
    report_error($sformatf("Mismatch at %0t ns: %s expected %s, got %s",
                           $time, name, exp_s, act_s));
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [95:0] expected_header(cpl_cmd_t c, logic hd);
    logic [9:0] len;
    logic [7:0] fmt;
    len = hd ? 10'((c.byte_count + 12'd3) >> 2) : 10'd0;  // Ceil to DW
    fmt = hd ? `CPL_FMT_CPLD : `CPL_FMT_CPL;
    return {1'b0, c.lower_addr, c.tag, c.requester_id[7:0], c.requester_id[15:8],
            c.byte_count[7:0], c.status, 1'b0, c.byte_count[11:8],
            completer_id_i[7:0], completer_id_i[15:8], len[7:0], 6'b0, len[9:8],
            8'h00, fmt};
  endfunction

  task automatic expect_completion(cpl_cmd_t c);
    logic     hd;
    logic [1:0] nb;
    tl_beat_t b;
    hd = c.has_data && (c.status == CPL_SC);                 // UR/CRS header-only
    nb = (hd && c.byte_count > 12'd4) ? 2'((c.byte_count - 12'd4 + 12'd15) / 12'd16) : 2'd0;
    b      = '0;
    b.data = {(hd ? c.data[31:0] : 32'h0), expected_header(c, hd)};
    b.be   = (hd && nb == 2'd0) ? c.first_be : 4'hF;
    b.sop  = 1'b1;
    b.eop  = (nb == 2'd0);
    beat_q.push_back(b);
    need_q.push_back({1'b1, hd});                            // Header plus DW0 credit
    if (nb != 2'd0) begin
      b      = '0;
      b.data = c.data[159:32];
      b.be   = (nb == 2'd1) ? c.last_be : 4'hF;
      b.eop  = (nb == 2'd1);
      beat_q.push_back(b);
      need_q.push_back(2'b01);
    end
    if (nb == 2'd2) begin
      b      = '0;
      b.data = {32'h0, c.data[255:160]};                     // Top DW padded
      b.be   = c.last_be;
      b.eop  = 1'b1;
      beat_q.push_back(b);
      need_q.push_back(2'b01);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic new_command();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd2:    cpl_cmd_i.status = CPL_UR;
      2'd3:    cpl_cmd_i.status = CPL_CRS;
      default: cpl_cmd_i.status = CPL_SC;
    endcase
    cpl_cmd_i.byte_count = 12'(r[6:2]) + 12'd1;              // 1..32
    cpl_cmd_i.has_data   = r[7] | r[31];
    cpl_cmd_i.first_be   = r[11:8];
    cpl_cmd_i.last_be    = r[15:12];
    cpl_cmd_i.tag        = r[23:16];
    cpl_cmd_i.lower_addr = r[30:24];
    r = $random(seed);
    cpl_cmd_i.requester_id = r[15:0];
    for (int i = 0; i < 8; i++) begin
      cpl_cmd_i.data[i*32 +: 32] = $random(seed);
    end
    if (n_gen < `CPL_MAX_BYTES) begin                        // Sweep every CplD size first
      cpl_cmd_i.status     = CPL_SC;
      cpl_cmd_i.has_data   = 1'b1;
      cpl_cmd_i.byte_count = 12'(n_gen + 1);
    end
    n_gen++;
  endtask

  task automatic drive_inputs();
    if (cmd_taken) begin
      new_command();
      cmd_taken = 1'b0;
    end
    cmd_valid_i    = (n_acc < N_CMDS) && (($random(seed) & 3) != 0);
    cred_hdr_ok_i  = ($random(seed) & 3) != 0;
    cred_data_ok_i = ($random(seed) & 3) != 0;
    pkt_ready_i    = ($random(seed) & 3) != 0;
  endtask

  // One cycle of checks, inputs already settled
  task automatic check_cycle();
    logic       exp_valid;
    logic [1:0] need;
    tl_beat_t   exp_beat;
    int         nxt;
    nxt       = phase;
    exp_valid = 1'b0;
    assert (cmd_ready_o === (phase == 0)) else
      report_mismatch("cmd_ready_o", $sformatf("%b", phase == 0), $sformatf("%b", cmd_ready_o));
    if (phase == 2) begin
      need      = need_q[0];
      exp_valid = (!need[1] || cred_hdr_ok_i) && (!need[0] || cred_data_ok_i);
    end
    assert (pkt_valid_o === exp_valid) else
      report_mismatch("pkt_valid_o", $sformatf("%b", exp_valid), $sformatf("%b", pkt_valid_o));
    if (pkt_valid_o && pkt_ready_i) begin
      exp_beat = beat_q.pop_front();
      void'(need_q.pop_front());
      assert (pkt_o === exp_beat) else
        report_mismatch("pkt_o", $sformatf("%h", exp_beat), $sformatf("%h", pkt_o));
      if (exp_beat.eop) nxt = 0;                             // Idle on the next cycle
    end
    if (phase == 1) nxt = 2;                                 // Header offered at T+2
    if (cmd_valid_i && cmd_ready_o) begin
      expect_completion(cpl_cmd_i);
      n_acc++;
      cmd_taken = 1'b1;
      nxt       = 1;
    end
    phase = nxt;
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    cmd_valid_i    = 1'b0;
    cred_hdr_ok_i  = 1'b0;
    cred_data_ok_i = 1'b0;
    pkt_ready_i    = 1'b0;
    cpl_cmd_i      = '0;
    completer_id_i = 16'($random(seed));                     // Fixed for the run
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (cmd_ready_o === 1'b1 && pkt_valid_o === 1'b0) else
      report_error("DUT not idle after reset");
    new_command();
    while (n_acc < N_CMDS || phase != 0) begin
      @(negedge clk);
      drive_inputs();
      #1;
      check_cycle();
    end
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_error("Watchdog expired before all completions were sent");
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/tl_stream_pkg.sv
rtl/cpl_pkg.sv
rtl/cpl_ctrl.sv
rtl/cpl_hdr_build.sv
rtl/cpl_beat_pack.sv
rtl/cpl_gen_top.sv
tests/tb_cpl_gen.sv

//--- run.sh
#!/bin/sh
# Build and run the completion generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_cpl_gen -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

./obj_dir/Vtb_cpl_gen
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0
